// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_nf_shell
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Test completed successfully

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "Simulation PASSED"; \
	else echo "Simulation FAILED, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+common
common/reg_bus_pkg.sv
common/platform_pkg.sv
logic/reset_sequencer.sv
reg_bus/reg_addr_decoder.sv
reg_bus/reg_slave_block.sv
reg_bus/reg_resp_mux.sv
logic/nf_shell_top.sv
dv/tb_clock_gen.sv
dv/nf_shell_assert.sv
dv/tb_nf_shell.sv

// ==== common/platform_pkg.sv ====
package platform_pkg;

  // Core stays in HOLD until the reset counter expires
  typedef enum logic {
    HOLD = 1'b0,
    RUN  = 1'b1
  } rst_state_e;

  typedef struct packed {
    rst_state_e state;
    logic       busy;
  } core_status_t;

endpackage

// ==== common/reg_bus_pkg.sv ====
`include "shell_defs.svh"

package reg_bus_pkg;

  typedef enum logic {
    READ  = 1'b0,
    WRITE = 1'b1
  } reg_op_e;

  // Same codes as AXI-Lite xRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } reg_resp_e;

  // ----------------------------------------
  // Single-beat transaction
  // ----------------------------------------
  typedef struct packed {
    reg_op_e                 op;
    logic [`REG_ADDR_W-1:0]  addr;
    logic [`REG_DATA_W-1:0]  wdata;
    logic [`REG_STRB_W-1:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [`REG_DATA_W-1:0]  rdata;
    reg_resp_e               resp;
  } reg_rsp_t;

endpackage

// ==== common/shell_defs.svh ====
`ifndef SHELL_DEFS_SVH
`define SHELL_DEFS_SVH

// ----------------------------------------
// Register bus geometry
// ----------------------------------------
`define REG_ADDR_W 32
`define REG_DATA_W 32
`define REG_STRB_W 4

// Slave index sits in addr[14:12]
`define NUM_SLAVES 8
`define SLAVE_SEL_LSB 12
`define REGS_PER_SLAVE 4

`define CORE_RST_CYCLES 16
`define SLAVE_ID_BASE 32'h5EC0_0000

`endif

// ==== dv/nf_shell_assert.sv ====
module nf_shell_assert (
  input logic                       core_clk,
  input logic                       rst_n,
  input logic                       req_valid,
  input logic                       req_ready,
  input logic                       rsp_valid,
  input logic                       rsp_ready,
  input reg_bus_pkg::reg_rsp_t      rsp,
  input platform_pkg::core_status_t status
);
  timeunit 1ns;
  timeprecision 1ps;

  int err_count = 0;

  a_hold_no_ready: assert property (@(posedge core_clk) disable iff (!rst_n)
    (status.state == platform_pkg::HOLD) |-> !req_ready)
    else begin
      $error("req_ready high while the core is held in reset");
      err_count++;
    end

  // Response must not move while the master stalls
  a_rsp_stable: assert property (@(posedge core_clk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else begin
      $error("response changed or dropped under back-pressure");
      err_count++;
    end

  a_no_overlap: assert property (@(posedge core_clk) disable iff (!rst_n)
    (req_valid && req_ready) |-> !rsp_valid)
    else begin
      $error("request accepted while a response is still pending");
      err_count++;
    end

endmodule

bind nf_shell_top nf_shell_assert i_assert (
  .core_clk  (core_clk),
  .rst_n     (rst_n),
  .req_valid (req_valid),
  .req_ready (req_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp       (rsp),
  .status    (status)
);

// ==== dv/reg_vectors.txt ====
# test op addr wdata wstrb exp_rdata exp_resp (test in decimal, the rest in hex)
# op 0 read, 1 write; resp 0 OKAY, 2 SLVERR, 3 DECERR
1 0 00000000 00000000 0 5EC00000 0
2 0 00001000 00000000 0 5EC00001 0
3 0 00002000 00000000 0 5EC00002 0
4 0 00003000 00000000 0 5EC00003 0
5 0 00004000 00000000 0 5EC00004 0
6 0 00005000 00000000 0 5EC00005 0
7 0 00006000 00000000 0 5EC00006 0
8 0 00007000 00000000 0 5EC00007 0
9 1 00002004 11223344 F 00000000 0
10 0 00002004 00000000 0 11223344 0
11 1 0000500C DEADBEEF F 00000000 0
12 0 0000500C 00000000 0 DEADBEEF 0
13 1 00007008 CAFEF00D F 00000000 0
14 0 00007008 00000000 0 CAFEF00D 0
15 1 00002004 AABBCCDD 5 00000000 0
16 0 00002004 00000000 0 11BB33DD 0
17 1 00003000 12345678 F 00000000 2
18 0 00003000 00000000 0 5EC00003 0
19 0 00008000 00000000 0 00000000 3
20 1 80002004 FFFFFFFF F 00000000 3
21 1 0000A004 FFFFFFFF F 00000000 3
22 0 00002004 00000000 0 11BB33DD 0

// ==== dv/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 8
) (
  output logic core_clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    core_clk = 1'b0;
    forever #(PERIOD_NS / 2) core_clk = ~core_clk;
  end

  // Release on a rising edge, like the driven inputs
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge core_clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== dv/tb_nf_shell.sv ====
`include "shell_defs.svh"

module tb_nf_shell;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RST_CYCLES    = 8;
  localparam int WAIT_LIMIT    = 40;

  typedef struct packed {
    logic [31:0] num;
    logic        op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp_rdata;
    logic [1:0]  exp_resp;
  } vec_t;

  logic                       core_clk;
  logic                       rst_n;
  logic                       req_valid;
  logic                       req_ready;
  logic                       rsp_valid;
  logic                       rsp_ready;
  reg_bus_pkg::reg_req_t      req;
  reg_bus_pkg::reg_rsp_t      rsp;
  platform_pkg::core_status_t status;

  vec_t                  vecs [$];
  reg_bus_pkg::reg_rsp_t taken [$];
  logic [7:0]            lfsr = 8'd78;
  logic                  loaded = 1'b0;
  int                    err_cnt = 0;
  int                    pass_cnt = 0;
  int                    fail_cnt = 0;

  tb_clock_gen #(
    .PERIOD_NS  (CLK_PERIOD_NS),
    .RST_CYCLES (RST_CYCLES)
  ) i_clk_gen (
    .core_clk (core_clk),
    .rst_n    (rst_n)
  );

  nf_shell_top i_dut (
    .core_clk  (core_clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready),
    .status    (status)
  );

  // Every response the master takes, in order
  always @(negedge core_clk) begin
    if (rst_n && rsp_valid) begin
      check_value("busy with a response pending", 32'(status.busy), 32'd1);
      if (rsp_ready) taken.push_back(rsp);
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          num;
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] wstrb;
    logic [31:0] rdata;
    logic [31:0] resp;
    fd = $fopen("dv/reg_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file dv/reg_vectors.txt");
      err_cnt++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%d %h %h %h %h %h %h", num, op, addr, wdata, wstrb, rdata, resp) == 7) begin
        vecs.push_back('{num: 32'(num), op: op[0], addr: addr, wdata: wdata,
                         wstrb: wstrb[3:0], exp_rdata: rdata, exp_resp: resp[1:0]});
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------
  // Reset hold and transactions
  // ----------------------------------------
  task automatic check_reset_hold();
    int hold_cycles;
    int errs_before;
    hold_cycles = 0;
    errs_before = err_cnt;
    @(negedge core_clk);
    while (status.state == platform_pkg::HOLD && hold_cycles < WAIT_LIMIT) begin
      check_value("req_ready during hold", 32'(req_ready), 32'd0);
      check_value("rsp_valid during hold", 32'(rsp_valid), 32'd0);
      check_value("busy during hold", 32'(status.busy), 32'd0);
      hold_cycles++;
      @(negedge core_clk);
    end
    check_value("state after hold", 32'(status.state), 32'(platform_pkg::RUN));
    check_value("reset hold cycles", 32'(hold_cycles), 32'(`CORE_RST_CYCLES));
    if (err_cnt == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("reset hold of %0d cycles: %s", hold_cycles,
             (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic run_vector(input vec_t v);
    logic [7:0]            r;
    int                    n;
    int                    errs_before;
    reg_bus_pkg::reg_rsp_t got;
    errs_before = err_cnt;
    take_bits(2, r);
    repeat (r) @(posedge core_clk);
    @(posedge core_clk);
    req_valid <= 1'b1;
    req       <= '{op: reg_bus_pkg::reg_op_e'(v.op), addr: v.addr, wdata: v.wdata,
                   wstrb: v.wstrb};
    n = 0;
    @(negedge core_clk);
    while (!req_ready && n < WAIT_LIMIT) begin
      n++;
      @(negedge core_clk);
    end
    if (req_ready) check_value("busy before request", 32'(status.busy), 32'd0);
    @(posedge core_clk);
    req_valid <= 1'b0;
    if (n >= WAIT_LIMIT) begin
      $display("Request of test %0d was not accepted within %0d cycles", v.num, WAIT_LIMIT);
      err_cnt++;
      fail_cnt++;
      return;
    end
    check_value("responses before request", 32'(taken.size()), 32'd0);
    // Random stalls on rsp_ready until the response is taken
    n = 0;
    while (taken.size() == 0 && n < WAIT_LIMIT) begin
      take_bits(2, r);
      rsp_ready <= |r;
      @(posedge core_clk);
      n++;
    end
    if (taken.size() == 0) begin
      $display("No response for test %0d within %0d cycles", v.num, WAIT_LIMIT);
      err_cnt++;
      fail_cnt++;
      return;
    end
    got = taken.pop_front();
    check_value("rdata", got.rdata, v.exp_rdata);
    check_value("resp", 32'(got.resp), 32'(v.exp_resp));
    if (err_cnt == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("test %0d %s %h: %s", v.num, v.op ? "write" : "read", v.addr,
             (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b1;
    load_vectors();
    if (vecs.size() == 0) begin
      $display("No vectors were loaded");
      err_cnt++;
    end
    loaded = 1'b1;
    wait (rst_n === 1'b1);
    check_reset_hold();
    foreach (vecs[i]) run_vector(vecs[i]);
    // Nothing else may come back
    rsp_ready <= 1'b1;
    repeat (8) @(posedge core_clk);
    check_value("responses beyond requests", 32'(taken.size()), 32'd0);
    $display("%0d tests passed, %0d tests failed, %0d errors, %0d assertion failures",
             pass_cnt, fail_cnt, err_cnt, i_dut.i_assert.err_count);
    if (err_cnt == 0 && fail_cnt == 0 && i_dut.i_assert.err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = vecs.size() * 200 + (RST_CYCLES + `CORE_RST_CYCLES) * CLK_PERIOD_NS;
    #(limit_ns);
    $display("The run timed out after %0t before all tests finished", $time);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== logic/nf_shell_top.sv ====
`include "shell_defs.svh"

module nf_shell_top (
  input  logic                       core_clk,
  input  logic                       rst_n,
  input  logic                       req_valid,
  input  reg_bus_pkg::reg_req_t      req,
  output logic                       req_ready,
  output logic                       rsp_valid,
  output reg_bus_pkg::reg_rsp_t      rsp,
  input  logic                       rsp_ready,
  output platform_pkg::core_status_t status
);

  logic                   core_run;
  logic                   busy;
  logic                   dec_err;
  logic                   rsp_done;
  logic [`NUM_SLAVES-1:0] slave_sel;
  logic [`NUM_SLAVES-1:0] slave_rsp_valid;
  reg_bus_pkg::reg_req_t  slave_req;
  reg_bus_pkg::reg_rsp_t  slave_rsp [`NUM_SLAVES];

  reset_sequencer i_reset_seq (
    .core_clk (core_clk),
    .rst_n    (rst_n),
    .core_run (core_run),
    .status   (status),
    .busy     (busy)
  );

  reg_addr_decoder i_decoder (
    .core_clk  (core_clk),
    .rst_n     (rst_n),
    .core_run  (core_run),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .busy      (busy),
    .rsp_done  (rsp_done),
    .slave_sel (slave_sel),
    .slave_req (slave_req),
    .dec_err   (dec_err)
  );

  // ----------------------------------------
  // Slave row
  // ----------------------------------------
  for (genvar i = 0; i < `NUM_SLAVES; i++) begin : g_slave
    reg_slave_block #(
      .SLAVE_INDEX (i)
    ) i_slave (
      .core_clk  (core_clk),
      .rst_n     (rst_n),
      .sel       (slave_sel[i]),
      .slave_req (slave_req),
      .rsp_valid (slave_rsp_valid[i]),
      .rsp       (slave_rsp[i])
    );
  end

  reg_resp_mux i_resp_mux (
    .core_clk        (core_clk),
    .rst_n           (rst_n),
    .slave_rsp_valid (slave_rsp_valid),
    .slave_rsp       (slave_rsp),
    .dec_err         (dec_err),
    .rsp_valid       (rsp_valid),
    .rsp             (rsp),
    .rsp_ready       (rsp_ready),
    .rsp_done        (rsp_done)
  );

endmodule

// ==== logic/reset_sequencer.sv ====
`include "shell_defs.svh"

module reset_sequencer (
  input  logic                       core_clk,
  input  logic                       rst_n,
  output logic                       core_run,
  output platform_pkg::core_status_t status,
  input  logic                       busy
);

  localparam int CNT_W = $clog2(`CORE_RST_CYCLES + 1);

  logic [CNT_W-1:0]         hold_cnt;
  platform_pkg::rst_state_e state;

  // Count cycles after release, then let the core run
  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt <= '0;
      state    <= platform_pkg::HOLD;
    end else if (state == platform_pkg::HOLD) begin
      if (hold_cnt == CNT_W'(`CORE_RST_CYCLES - 1)) begin
        state <= platform_pkg::RUN;
      end else begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  assign core_run = (state == platform_pkg::RUN);
  assign status   = '{state: state, busy: busy};

endmodule

// ==== reg_bus/reg_addr_decoder.sv ====
`include "shell_defs.svh"

module reg_addr_decoder (
  input  logic                   core_clk,
  input  logic                   rst_n,
  input  logic                   core_run,
  input  logic                   req_valid,
  input  reg_bus_pkg::reg_req_t  req,
  output logic                   req_ready,
  output logic                   busy,
  input  logic                   rsp_done,
  output logic [`NUM_SLAVES-1:0] slave_sel,
  output reg_bus_pkg::reg_req_t  slave_req,
  output logic                   dec_err
);

  localparam int IDX_W = $clog2(`NUM_SLAVES);

  typedef enum logic {IDLE, WAIT} dec_state_e;

  dec_state_e       state;
  logic             take;
  logic             pend;
  logic             addr_bad;
  logic [IDX_W-1:0] slave_idx;

  // One transaction in flight at a time
  assign req_ready = core_run && (state == IDLE);
  assign busy      = (state == WAIT);
  assign take      = req_valid && req_ready;

  assign slave_idx = slave_req.addr[`SLAVE_SEL_LSB +: IDX_W];
  assign addr_bad  = |slave_req.addr[`REG_ADDR_W-1:`SLAVE_SEL_LSB+IDX_W];

  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      pend      <= 1'b0;
      slave_sel <= '0;
      dec_err   <= 1'b0;
    end else begin
      pend      <= take;
      slave_sel <= '0;
      dec_err   <= 1'b0;
      // Strobe out one cycle after acceptance
      if (pend) begin
        if (addr_bad) begin
          dec_err <= 1'b1;
        end else begin
          slave_sel <= {{(`NUM_SLAVES - 1){1'b0}}, 1'b1} << slave_idx;
        end
      end
      case (state)
        IDLE:    if (take) state <= WAIT;
        WAIT:    if (rsp_done) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (take) slave_req <= req;
  end

endmodule

// ==== reg_bus/reg_resp_mux.sv ====
`include "shell_defs.svh"

module reg_resp_mux (
  input  logic                   core_clk,
  input  logic                   rst_n,
  input  logic [`NUM_SLAVES-1:0] slave_rsp_valid,
  input  reg_bus_pkg::reg_rsp_t  slave_rsp [`NUM_SLAVES],
  input  logic                   dec_err,
  output logic                   rsp_valid,
  output reg_bus_pkg::reg_rsp_t  rsp,
  input  logic                   rsp_ready,
  output logic                   rsp_done
);

  reg_bus_pkg::reg_rsp_t pick;
  logic                  new_rsp;

  // Falls back to DECERR when no slave answered
  always_comb begin
    pick = '{rdata: '0, resp: reg_bus_pkg::DECERR};
    for (int i = 0; i < `NUM_SLAVES; i++) begin
      if (slave_rsp_valid[i]) pick = slave_rsp[i];
    end
  end

  assign new_rsp  = (|slave_rsp_valid) || dec_err;
  assign rsp_done = rsp_valid && rsp_ready;

  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (new_rsp) begin
      rsp_valid <= 1'b1;
    end else if (rsp_done) begin
      rsp_valid <= 1'b0;
    end
  end

  // Held until the master takes it
  always_ff @(posedge core_clk) begin
    if (new_rsp) rsp <= pick;
  end

endmodule

// ==== reg_bus/reg_slave_block.sv ====
`include "shell_defs.svh"

module reg_slave_block #(
  parameter int SLAVE_INDEX = 0
) (
  input  logic                  core_clk,
  input  logic                  rst_n,
  input  logic                  sel,
  input  reg_bus_pkg::reg_req_t slave_req,
  output logic                  rsp_valid,
  output reg_bus_pkg::reg_rsp_t rsp
);

  localparam int WORD_W = $clog2(`REGS_PER_SLAVE);
  localparam logic [`REG_DATA_W-1:0] ID_WORD = `SLAVE_ID_BASE + `REG_DATA_W'(SLAVE_INDEX);

  logic [`REG_DATA_W-1:0] scratch [1:`REGS_PER_SLAVE-1];
  logic [WORD_W-1:0]      word;
  logic                   is_write;
  logic [`REG_DATA_W-1:0] rd_data;
  reg_bus_pkg::reg_resp_e rd_resp;

  assign word     = slave_req.addr[2 +: WORD_W];
  assign is_write = (slave_req.op == reg_bus_pkg::WRITE);

  // Word 0 is the ID and refuses writes
  always_comb begin
    rd_data = '0;
    rd_resp = reg_bus_pkg::OKAY;
    if (word == '0) begin
      rd_data = ID_WORD;
      if (is_write) rd_resp = reg_bus_pkg::SLVERR;
    end else begin
      rd_data = scratch[word];
    end
    if (is_write) rd_data = '0;
  end

  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      for (int i = 1; i < `REGS_PER_SLAVE; i++) scratch[i] <= '0;
    end else begin
      rsp_valid <= sel;
      if (sel && is_write && word != '0) begin
        for (int b = 0; b < `REG_STRB_W; b++) begin
          if (slave_req.wstrb[b]) scratch[word][b*8 +: 8] <= slave_req.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (sel) rsp <= '{rdata: rd_data, resp: rd_resp};
  end

endmodule
